// File: verilog/decode_pkg.sv
// ==========================================================
// Decode stage package
// Widths, opcode and prefix codes, and the stage structs
// ==========================================================
package decode_pkg;

  localparam int WINDOW_BYTES = 16;
  localparam int EIP_W        = 32;

  typedef logic [2:0] reg_idx_t;

  typedef enum logic [3:0] {
    ALU_NONE = 4'd0,
    ALU_ADD  = 4'd1,
    ALU_PASS = 4'd2
  } alu_op_t;

  // Prefix bytes
  localparam logic [7:0] PFX_REPNE = 8'hF2;
  localparam logic [7:0] PFX_CS    = 8'h2E;
  localparam logic [7:0] PFX_SS    = 8'h36;
  localparam logic [7:0] PFX_DS    = 8'h3E;
  localparam logic [7:0] PFX_ES    = 8'h26;
  localparam logic [7:0] PFX_FS    = 8'h64;
  localparam logic [7:0] PFX_GS    = 8'h65;
  localparam logic [7:0] PFX_SIZE  = 8'h66;
  localparam logic [7:0] PFX_0F    = 8'h0F;

  // Segment numbers
  localparam reg_idx_t SEG_ES = 3'd0;
  localparam reg_idx_t SEG_CS = 3'd1;
  localparam reg_idx_t SEG_SS = 3'd2;
  localparam reg_idx_t SEG_DS = 3'd3;
  localparam reg_idx_t SEG_FS = 3'd4;
  localparam reg_idx_t SEG_GS = 3'd5;

  localparam reg_idx_t REG_ESP = 3'd4;

  // Opcodes, one-byte map unless noted
  localparam logic [7:0] OP_ADD_RM_R    = 8'h01;
  localparam logic [7:0] OP_ADD_R_RM    = 8'h03;
  localparam logic [7:0] OP_ADD_EAX_IMM = 8'h05;
  localparam logic [7:0] OP_MOV_RM_R    = 8'h89;
  localparam logic [7:0] OP_MOV_R_RM    = 8'h8B;
  localparam logic [7:0] OP_MOV_R_IMM   = 8'hB8;
  localparam logic [7:0] OP_PUSH_R      = 8'h50;
  localparam logic [7:0] OP_POP_R       = 8'h58;
  localparam logic [7:0] OP_NOP         = 8'h90;
  localparam logic [7:0] OP_CALL_REL    = 8'hE8;
  localparam logic [7:0] OP_JMP_REL8    = 8'hEB;
  localparam logic [7:0] OP_HLT         = 8'hF4;
  localparam logic [7:0] OP_IRET        = 8'hCF;
  // 0F map
  localparam logic [7:0] OP_JZ_REL      = 8'h84;

  // Flag load mask, order OF DF SF ZF AF PF CF
  localparam logic [6:0] FLAGS_OSZAPC = 7'b101_1111;

  typedef struct packed {
    logic                        valid;
    logic [15:0]                 cs;
    logic [EIP_W-1:0]            eip;
    logic [WINDOW_BYTES*8-1:0]   bytes;
  } fetch_t;

  typedef struct packed {
    logic [2:0] count;
    logic       repne;
    logic       size_over;
    logic       map_0f;
    logic       seg_over;
    reg_idx_t   seg;
  } prefix_t;

  typedef struct packed {
    logic       legal;
    logic       modrm_pr;
    logic       reg_override;
    logic [2:0] imm_bytes;
    logic       sr1_rm;
    logic       sr2_rm;
    logic       sr1_needed;
    logic       sr2_needed;
    logic       ld_sr1;
    logic       ld_sr2;
    logic       esp_needed;
    logic       stack_read;
    logic       stack_write;
    alu_op_t    alu_op;
    logic [6:0] ld_flags;
    logic       eip_change;
    logic       hlt;
    logic       iret;
  } op_ctrl_t;

  typedef struct packed {
    logic [7:0]       opcode;
    logic [7:0]       modrm;
    logic [7:0]       sib;
    logic             sib_pr;
    logic [2:0]       disp_bytes;
    logic [31:0]      disp32;
    logic [31:0]      imm32;
    logic [4:0]       len;
    logic [EIP_W-1:0] eip_next;
  } fields_t;

  typedef struct packed {
    logic [EIP_W-1:0] eip;
    logic [15:0]      cs;
    prefix_t          prefix;
    op_ctrl_t         ctrl;
    fields_t          fields;
    reg_idx_t         in1;
    reg_idx_t         in2;
    reg_idx_t         dreg;
    logic             in1_needed;
    logic             in2_needed;
    logic             ld_reg;
    logic             mem_read;
    logic             ld_mem;
  } decode_t;

endpackage

// File: verilog/prefix_scan.sv
// ==========================================================
// Prefix scan: counts and classifies leading prefix bytes
// ==========================================================
`timescale 1ns/1ps

module prefix_scan #(
  parameter int MAX_PREFIXES = 4
) (
  input  logic [decode_pkg::WINDOW_BYTES*8-1:0] window,
  output decode_pkg::prefix_t                   prefix
);
  import decode_pkg::*;

  logic [MAX_PREFIXES-1:0] hit_repne;
  logic [MAX_PREFIXES-1:0] hit_size;
  logic [MAX_PREFIXES-1:0] hit_0f;
  logic [MAX_PREFIXES-1:0] hit_es;
  logic [MAX_PREFIXES-1:0] hit_cs;
  logic [MAX_PREFIXES-1:0] hit_ss;
  logic [MAX_PREFIXES-1:0] hit_ds;
  logic [MAX_PREFIXES-1:0] hit_fs;
  logic [MAX_PREFIXES-1:0] hit_gs;
  logic [MAX_PREFIXES-1:0] is_pfx;
  logic [MAX_PREFIXES-1:0] run;
  logic [5:0]              seg_any;

  genvar g;
  for (g = 0; g < MAX_PREFIXES; g++) begin : g_byte
    logic [7:0] b;
    assign b = window[g*8 +: 8];
    assign hit_repne[g] = (b == PFX_REPNE);
    assign hit_size[g]  = (b == PFX_SIZE);
    assign hit_0f[g]    = (b == PFX_0F);
    assign hit_es[g]    = (b == PFX_ES);
    assign hit_cs[g]    = (b == PFX_CS);
    assign hit_ss[g]    = (b == PFX_SS);
    assign hit_ds[g]    = (b == PFX_DS);
    assign hit_fs[g]    = (b == PFX_FS);
    assign hit_gs[g]    = (b == PFX_GS);
    assign is_pfx[g] = hit_repne[g] | hit_size[g] | hit_0f[g] | hit_es[g] | hit_cs[g] |
                       hit_ss[g] | hit_ds[g] | hit_fs[g] | hit_gs[g];
    // Run stops at the first non-prefix byte
    if (g == 0) begin : g_first
      assign run[g] = is_pfx[g];
    end else begin : g_next
      assign run[g] = run[g-1] & is_pfx[g];
    end
  end

  // Segment hits inside the run, ES in bit 0
  assign seg_any = {|(hit_gs & run), |(hit_fs & run), |(hit_ds & run),
                    |(hit_ss & run), |(hit_cs & run), |(hit_es & run)};

  always_comb begin
    prefix           = '0;
    for (int i = 0; i < MAX_PREFIXES; i++) begin
      if (run[i]) begin
        prefix.count = prefix.count + 3'd1;
      end
    end
    prefix.repne     = |(hit_repne & run);
    prefix.size_over = |(hit_size & run);
    prefix.map_0f    = |(hit_0f & run);
    prefix.seg_over  = |seg_any;
    // Fixed priority, not byte order
    if (seg_any[0])      prefix.seg = SEG_ES;
    else if (seg_any[1]) prefix.seg = SEG_CS;
    else if (seg_any[2]) prefix.seg = SEG_SS;
    else if (seg_any[3]) prefix.seg = SEG_DS;
    else if (seg_any[4]) prefix.seg = SEG_FS;
    else if (seg_any[5]) prefix.seg = SEG_GS;
    else                 prefix.seg = SEG_ES;
  end

endmodule

// File: verilog/opcode_table.sv
// ==========================================================
// Opcode table: control bundle for the supported subset
// ==========================================================
`timescale 1ns/1ps

module opcode_table (
  input  logic [7:0]           opcode,
  input  logic                 map_0f,
  input  logic                 size_over,
  output decode_pkg::op_ctrl_t ctrl
);
  import decode_pkg::*;

  logic       reg_group;
  logic [7:0] base_op;
  logic [2:0] imm_full;

  // PUSH, POP and MOV r,imm carry the register in bits 2:0
  assign reg_group = !map_0f && ((opcode[7:3] == OP_PUSH_R[7:3]) ||
                                 (opcode[7:3] == OP_POP_R[7:3])  ||
                                 (opcode[7:3] == OP_MOV_R_IMM[7:3]));
  assign base_op   = reg_group ? {opcode[7:3], 3'b000} : opcode;

  // Word-sized immediates shrink under 66
  assign imm_full  = size_over ? 3'd2 : 3'd4;

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = ALU_NONE;
    if (map_0f) begin
      if (opcode == OP_JZ_REL) begin
        ctrl.legal      = 1'b1;
        ctrl.imm_bytes  = imm_full;
        ctrl.eip_change = 1'b1;
      end
    end else begin
      case (base_op)
        OP_ADD_RM_R: begin
          ctrl.legal      = 1'b1;
          ctrl.modrm_pr   = 1'b1;
          ctrl.sr1_rm     = 1'b1;
          ctrl.sr1_needed = 1'b1;
          ctrl.sr2_needed = 1'b1;
          ctrl.ld_sr1     = 1'b1;
          ctrl.alu_op     = ALU_ADD;
          ctrl.ld_flags   = FLAGS_OSZAPC;
        end
        OP_ADD_R_RM: begin
          ctrl.legal      = 1'b1;
          ctrl.modrm_pr   = 1'b1;
          ctrl.sr2_rm     = 1'b1;
          ctrl.sr1_needed = 1'b1;
          ctrl.sr2_needed = 1'b1;
          ctrl.ld_sr1     = 1'b1;
          ctrl.alu_op     = ALU_ADD;
          ctrl.ld_flags   = FLAGS_OSZAPC;
        end
        OP_ADD_EAX_IMM: begin
          // No ModRM, so the reg field reads 0 which is EAX
          ctrl.legal      = 1'b1;
          ctrl.imm_bytes  = imm_full;
          ctrl.sr1_needed = 1'b1;
          ctrl.ld_sr1     = 1'b1;
          ctrl.alu_op     = ALU_ADD;
          ctrl.ld_flags   = FLAGS_OSZAPC;
        end
        OP_MOV_RM_R: begin
          ctrl.legal      = 1'b1;
          ctrl.modrm_pr   = 1'b1;
          ctrl.sr1_rm     = 1'b1;
          ctrl.sr2_needed = 1'b1;
          ctrl.ld_sr1     = 1'b1;
          ctrl.alu_op     = ALU_PASS;
        end
        OP_MOV_R_RM: begin
          ctrl.legal      = 1'b1;
          ctrl.modrm_pr   = 1'b1;
          ctrl.sr2_rm     = 1'b1;
          ctrl.sr2_needed = 1'b1;
          ctrl.ld_sr1     = 1'b1;
          ctrl.alu_op     = ALU_PASS;
        end
        OP_MOV_R_IMM: begin
          ctrl.legal        = 1'b1;
          ctrl.reg_override = 1'b1;
          ctrl.imm_bytes    = imm_full;
          ctrl.ld_sr1       = 1'b1;
          ctrl.alu_op       = ALU_PASS;
        end
        OP_PUSH_R: begin
          ctrl.legal        = 1'b1;
          ctrl.reg_override = 1'b1;
          ctrl.sr1_needed   = 1'b1;
          ctrl.esp_needed   = 1'b1;
          ctrl.stack_write  = 1'b1;
        end
        OP_POP_R: begin
          ctrl.legal        = 1'b1;
          ctrl.reg_override = 1'b1;
          ctrl.esp_needed   = 1'b1;
          ctrl.stack_read   = 1'b1;
        end
        OP_NOP: ctrl.legal = 1'b1;
        OP_CALL_REL: begin
          ctrl.legal       = 1'b1;
          ctrl.imm_bytes   = imm_full;
          ctrl.esp_needed  = 1'b1;
          ctrl.stack_write = 1'b1;
          ctrl.eip_change  = 1'b1;
        end
        OP_JMP_REL8: begin
          ctrl.legal      = 1'b1;
          ctrl.imm_bytes  = 3'd1;
          ctrl.eip_change = 1'b1;
        end
        OP_HLT: begin
          ctrl.legal = 1'b1;
          ctrl.hlt   = 1'b1;
        end
        OP_IRET: begin
          ctrl.legal      = 1'b1;
          ctrl.esp_needed = 1'b1;
          ctrl.stack_read = 1'b1;
          ctrl.iret       = 1'b1;
        end
        default: ctrl = '0;
      endcase
    end
  end

endmodule

// File: verilog/instr_fields.sv
// ==========================================================
// Instruction fields: ModRM, SIB, displacement, immediate,
// instruction length and next EIP
// ==========================================================
`timescale 1ns/1ps

module instr_fields (
  input  logic [decode_pkg::WINDOW_BYTES*8-1:0] window,
  input  logic [decode_pkg::EIP_W-1:0]          eip,
  input  decode_pkg::prefix_t                   prefix,
  input  decode_pkg::op_ctrl_t                  ctrl,
  output decode_pkg::fields_t                   fields
);
  import decode_pkg::*;

  logic [4:0]  op_off;
  logic [4:0]  disp_off;
  logic [4:0]  imm_off;
  logic [4:0]  len;
  logic [31:0] op_word;
  logic [31:0] modrm_word;
  logic [31:0] sib_word;
  logic [31:0] disp_word;
  logic [31:0] imm_word;
  logic [7:0]  modrm;
  logic [1:0]  mod;
  logic [2:0]  rm;
  logic        sib_pr;
  logic [2:0]  disp_bytes;

  // Four bytes from a byte offset, little-endian, zero past the end
  function automatic logic [31:0] dword_at(input logic [WINDOW_BYTES*8-1:0] win,
                                           input logic [4:0]                off);
    logic [WINDOW_BYTES*8-1:0] shifted;
    shifted = win >> {off, 3'b000};
    return shifted[31:0];
  endfunction

  // Opcode sits right after the prefix run
  assign op_off     = {2'b00, prefix.count};
  assign op_word    = dword_at(window, op_off);
  assign modrm_word = dword_at(window, op_off + 5'd1);
  assign sib_word   = dword_at(window, op_off + 5'd2);

  assign modrm  = ctrl.modrm_pr ? modrm_word[7:0] : 8'h00;
  assign mod    = modrm[7:6];
  assign rm     = modrm[2:0];
  assign sib_pr = ctrl.modrm_pr && (mod != 2'b11) && (rm == 3'b100);

  always_comb begin
    disp_bytes = 3'd0;
    if (ctrl.modrm_pr) begin
      case (mod)
        2'b00:   disp_bytes = (rm == 3'b101) ? 3'd4 : 3'd0;
        2'b01:   disp_bytes = 3'd1;
        2'b10:   disp_bytes = 3'd4;
        default: disp_bytes = 3'd0;
      endcase
    end
  end

  assign disp_off  = op_off + 5'd1 + {4'd0, ctrl.modrm_pr} + {4'd0, sib_pr};
  assign imm_off   = disp_off + {2'b00, disp_bytes};
  assign len       = imm_off + {2'b00, ctrl.imm_bytes};
  assign disp_word = dword_at(window, disp_off);
  assign imm_word  = dword_at(window, imm_off);

  always_comb begin
    fields            = '0;
    fields.opcode     = op_word[7:0];
    fields.modrm      = modrm;
    fields.sib        = sib_pr ? sib_word[7:0] : 8'h00;
    fields.sib_pr     = sib_pr;
    fields.disp_bytes = disp_bytes;
    fields.disp32     = (disp_bytes != 3'd0) ? disp_word : 32'h0;
    fields.imm32      = (ctrl.imm_bytes != 3'd0) ? imm_word : 32'h0;
    fields.len        = len;
    fields.eip_next   = eip + EIP_W'(len);
  end

endmodule

// File: verilog/register_select.sv
// ==========================================================
// Register select: source/dest specifiers, memory controls
// ==========================================================
`timescale 1ns/1ps

module register_select (
  input  decode_pkg::op_ctrl_t ctrl,
  input  logic [7:0]           modrm,
  input  logic [7:0]           opcode,
  output decode_pkg::reg_idx_t in1,
  output decode_pkg::reg_idx_t in2,
  output decode_pkg::reg_idx_t dreg,
  output logic                 in1_needed,
  output logic                 in2_needed,
  output logic                 ld_reg,
  output logic                 mem_read,
  output logic                 ld_mem
);
  import decode_pkg::*;

  reg_idx_t reg_f;
  reg_idx_t rm;
  logic     mem_form;
  logic     rm_src;
  logic     mem_dest;
  logic     pop_op;

  assign reg_f = ctrl.reg_override ? opcode[2:0] : modrm[5:3];
  assign rm    = modrm[2:0];

  // r/m names memory unless mod is 11
  assign mem_form = ctrl.modrm_pr && (modrm[7:6] != 2'b11);

  assign in1  = ctrl.sr1_rm ? rm : reg_f;
  assign in2  = ctrl.esp_needed ? REG_ESP : (ctrl.sr2_rm ? rm : reg_f);
  assign dreg = in1;

  assign in1_needed = ctrl.sr1_needed;
  assign in2_needed = ctrl.sr2_needed | ctrl.esp_needed;

  assign rm_src   = (ctrl.sr1_rm & ctrl.sr1_needed) | (ctrl.sr2_rm & ctrl.sr2_needed);
  assign mem_dest = ctrl.ld_sr1 & ctrl.sr1_rm & mem_form;
  // POP writes the register named in the opcode
  assign pop_op   = ctrl.stack_read & ctrl.reg_override;

  assign ld_reg   = (ctrl.ld_sr1 & ~mem_dest) | pop_op;
  assign mem_read = ctrl.stack_read | (rm_src & mem_form);
  assign ld_mem   = ctrl.stack_write | mem_dest;

endmodule

// File: verilog/decode_stage.sv
// ==========================================================
// Decode stage top: prefix scan, table lookup, field
// extraction and the stall-held output register
// ==========================================================
`timescale 1ns/1ps

module decode_stage #(
  parameter int MAX_PREFIXES = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                stall,
  input  decode_pkg::fetch_t  fetch,
  output decode_pkg::decode_t dec,
  output logic                dec_valid
);
  import decode_pkg::*;

  prefix_t  prefix;
  op_ctrl_t ctrl;
  fields_t  fields;
  reg_idx_t in1;
  reg_idx_t in2;
  reg_idx_t dreg;
  logic     in1_needed;
  logic     in2_needed;
  logic     ld_reg;
  logic     mem_read;
  logic     ld_mem;
  decode_t  dec_next;

  prefix_scan #(
    .MAX_PREFIXES(MAX_PREFIXES)
  ) u_prefix_scan (
    .window (fetch.bytes),
    .prefix (prefix)
  );

  instr_fields u_instr_fields (
    .window (fetch.bytes),
    .eip    (fetch.eip),
    .prefix (prefix),
    .ctrl   (ctrl),
    .fields (fields)
  );

  opcode_table u_opcode_table (
    .opcode    (fields.opcode),
    .map_0f    (prefix.map_0f),
    .size_over (prefix.size_over),
    .ctrl      (ctrl)
  );

  register_select u_register_select (
    .ctrl       (ctrl),
    .modrm      (fields.modrm),
    .opcode     (fields.opcode),
    .in1        (in1),
    .in2        (in2),
    .dreg       (dreg),
    .in1_needed (in1_needed),
    .in2_needed (in2_needed),
    .ld_reg     (ld_reg),
    .mem_read   (mem_read),
    .ld_mem     (ld_mem)
  );

  always_comb begin
    dec_next            = '0;
    dec_next.eip        = fetch.eip;
    dec_next.cs         = fetch.cs;
    dec_next.prefix     = prefix;
    dec_next.ctrl       = ctrl;
    dec_next.fields     = fields;
    dec_next.in1        = in1;
    dec_next.in2        = in2;
    dec_next.dreg       = dreg;
    dec_next.in1_needed = in1_needed;
    dec_next.in2_needed = in2_needed;
    dec_next.ld_reg     = ld_reg;
    dec_next.mem_read   = mem_read;
    dec_next.ld_mem     = ld_mem;
  end

  // Output stage holds while stalled
  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
      dec       <= '0;
    end else if (!stall) begin
      dec_valid <= fetch.valid;
      dec       <= dec_next;
    end
  end

endmodule

// File: bench/tb_decode_stage.sv
// ==========================================================
// Decode stage testbench: directed windows against a model
// ==========================================================
`timescale 1ns/1ps

module tb_decode_stage;
  import decode_pkg::*;

  localparam int MAX_PFX = 4;
  // Reset, then two cycles per window, with margin for the stall test
  localparam int N_CASES    = 160;
  localparam int MAX_CYCLES = 16 + 3 * N_CASES;

  logic      clk = 1'b0;
  logic      reset;
  logic      stall;
  fetch_t    fetch;
  decode_t   dec;
  logic      dec_valid;

  logic [15:0] lfsr = 16'd30561;
  logic [7:0]  ins_q[$];
  int          n_checks = 0;
  int          n_errors = 0;
  int          cycles = 0;

  decode_stage #(
    .MAX_PREFIXES(MAX_PFX)
  ) u_dut (
    .clk       (clk),
    .reset     (reset),
    .stall     (stall),
    .fetch     (fetch),
    .dec       (dec),
    .dec_valid (dec_valid)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Run stopped: no end of test after %0d cycles", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic logic [7:0] byte_at(input fetch_t f, input int idx);
    if (idx >= WINDOW_BYTES) return 8'h00;
    return f.bytes[idx*8 +: 8];
  endfunction

  function automatic logic [31:0] dword_le(input fetch_t f, input int idx);
    return {byte_at(f, idx + 3), byte_at(f, idx + 2), byte_at(f, idx + 1), byte_at(f, idx)};
  endfunction

  function automatic op_ctrl_t ref_ctrl(input logic [7:0] op, input logic m0f, input logic s66);
    op_ctrl_t   c;
    logic [2:0] iw;
    c  = '0;
    iw = s66 ? 3'd2 : 3'd4;
    if (m0f) begin
      if (op == 8'h84) begin
        c.legal      = 1'b1;
        c.imm_bytes  = iw;
        c.eip_change = 1'b1;
      end
    end else begin
      c.legal = 1'b1;
      case (op)
        8'h01, 8'h03, 8'h89, 8'h8B: begin
          c.modrm_pr   = 1'b1;
          c.ld_sr1     = 1'b1;
          c.sr1_rm     = (op == 8'h01) || (op == 8'h89);
          c.sr2_rm     = !c.sr1_rm;
          c.sr1_needed = !op[7];
          c.sr2_needed = 1'b1;
          c.alu_op     = op[7] ? ALU_PASS : ALU_ADD;
          // OF SF ZF AF PF CF
          c.ld_flags   = op[7] ? 7'b000_0000 : 7'b101_1111;
        end
        8'h05: begin
          c.imm_bytes  = iw;
          c.sr1_needed = 1'b1;
          c.ld_sr1     = 1'b1;
          c.alu_op     = ALU_ADD;
          c.ld_flags   = 7'b101_1111;
        end
        8'h90: c.legal = 1'b1;
        8'hE8: begin
          c.imm_bytes   = iw;
          c.esp_needed  = 1'b1;
          c.stack_write = 1'b1;
          c.eip_change  = 1'b1;
        end
        8'hEB: begin
          c.imm_bytes  = 3'd1;
          c.eip_change = 1'b1;
        end
        8'hF4: c.hlt = 1'b1;
        8'hCF: begin
          c.esp_needed = 1'b1;
          c.stack_read = 1'b1;
          c.iret       = 1'b1;
        end
        default: begin
          if (op[7:3] == 5'b01010) begin
            c.reg_override = 1'b1;
            c.sr1_needed   = 1'b1;
            c.esp_needed   = 1'b1;
            c.stack_write  = 1'b1;
          end else if (op[7:3] == 5'b01011) begin
            c.reg_override = 1'b1;
            c.esp_needed   = 1'b1;
            c.stack_read   = 1'b1;
          end else if (op[7:3] == 5'b10111) begin
            c.reg_override = 1'b1;
            c.imm_bytes    = iw;
            c.ld_sr1       = 1'b1;
            c.alu_op       = ALU_PASS;
          end else begin
            c = '0;
          end
        end
      endcase
    end
    return c;
  endfunction

  function automatic decode_t ref_decode(input fetch_t f);
    decode_t    d;
    logic [5:0] segs;
    logic       run;
    logic       mem;
    logic       mem_dst;
    logic [2:0] regf;
    logic [7:0] b;
    int         cnt;
    int         pos;
    int         disp;
    d    = '0;
    segs = '0;
    run  = 1'b1;
    d.eip = f.eip;
    d.cs  = f.cs;
    for (int i = 0; i < MAX_PFX; i++) begin
      b = byte_at(f, i);
      if (run) begin
        case (b)
          8'hF2:   d.prefix.repne = 1'b1;
          8'h66:   d.prefix.size_over = 1'b1;
          8'h0F:   d.prefix.map_0f = 1'b1;
          8'h26:   segs[0] = 1'b1;
          8'h2E:   segs[1] = 1'b1;
          8'h36:   segs[2] = 1'b1;
          8'h3E:   segs[3] = 1'b1;
          8'h64:   segs[4] = 1'b1;
          8'h65:   segs[5] = 1'b1;
          default: run = 1'b0;
        endcase
        if (run) d.prefix.count = d.prefix.count + 3'd1;
      end
    end
    d.prefix.seg_over = |segs;
    // Lowest segment number wins
    for (int s = 5; s >= 0; s--) begin
      if (segs[s]) d.prefix.seg = 3'(s);
    end
    cnt = d.prefix.count;
    d.fields.opcode = byte_at(f, cnt);
    d.ctrl = ref_ctrl(d.fields.opcode, d.prefix.map_0f, d.prefix.size_over);
    disp = 0;
    if (d.ctrl.modrm_pr) begin
      d.fields.modrm  = byte_at(f, cnt + 1);
      d.fields.sib_pr = (d.fields.modrm[7:6] != 2'b11) && (d.fields.modrm[2:0] == 3'b100);
      if (d.fields.modrm[7:6] == 2'b01) disp = 1;
      else if (d.fields.modrm[7:6] == 2'b10) disp = 4;
      else if (d.fields.modrm[7:6] == 2'b00 && d.fields.modrm[2:0] == 3'b101) disp = 4;
    end
    if (d.fields.sib_pr) d.fields.sib = byte_at(f, cnt + 2);
    pos = cnt + 1 + int'(d.ctrl.modrm_pr) + int'(d.fields.sib_pr);
    d.fields.disp_bytes = 3'(disp);
    if (disp != 0) d.fields.disp32 = dword_le(f, pos);
    pos = pos + disp;
    if (d.ctrl.imm_bytes != 3'd0) d.fields.imm32 = dword_le(f, pos);
    pos = pos + int'(d.ctrl.imm_bytes);
    d.fields.len      = 5'(pos);
    d.fields.eip_next = f.eip + pos;
    regf    = d.ctrl.reg_override ? d.fields.opcode[2:0] : d.fields.modrm[5:3];
    mem     = d.ctrl.modrm_pr && (d.fields.modrm[7:6] != 2'b11);
    mem_dst = d.ctrl.ld_sr1 && d.ctrl.sr1_rm && mem;
    d.in1   = d.ctrl.sr1_rm ? d.fields.modrm[2:0] : regf;
    d.in2   = d.ctrl.esp_needed ? REG_ESP : (d.ctrl.sr2_rm ? d.fields.modrm[2:0] : regf);
    d.dreg  = d.in1;
    d.in1_needed = d.ctrl.sr1_needed;
    d.in2_needed = d.ctrl.sr2_needed || d.ctrl.esp_needed;
    d.ld_reg     = (d.ctrl.ld_sr1 && !mem_dst) || (d.ctrl.stack_read && d.ctrl.reg_override);
    d.mem_read   = d.ctrl.stack_read || (mem && ((d.ctrl.sr1_rm && d.ctrl.sr1_needed) ||
                                                 (d.ctrl.sr2_rm && d.ctrl.sr2_needed)));
    d.ld_mem     = d.ctrl.stack_write || mem_dst;
    return d;
  endfunction

  task automatic check(input string name, input logic [255:0] got, input logic [255:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %s got %0h expected %0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic build_window(output fetch_t f);
    f       = '0;
    f.valid = 1'b1;
    f.cs    = rand_bits(16);
    f.eip   = rand_bits(32);
    for (int i = 0; i < WINDOW_BYTES; i++) begin
      if (i < ins_q.size()) f.bytes[i*8 +: 8] = ins_q[i];
      else f.bytes[i*8 +: 8] = rand_bits(8);
    end
  endtask

  task automatic drive(input fetch_t f);
    @(posedge clk);
    #2;
    fetch = f;
  endtask

  task automatic check_dec(input fetch_t f);
    decode_t e;
    e = ref_decode(f);
    check("dec_valid", dec_valid, f.valid);
    check("dec.eip", dec.eip, e.eip);
    check("dec.cs", dec.cs, e.cs);
    check("dec.prefix", dec.prefix, e.prefix);
    check("dec.ctrl", dec.ctrl, e.ctrl);
    check("dec.fields", dec.fields, e.fields);
    check("dec.in1", dec.in1, e.in1);
    check("dec.in2", dec.in2, e.in2);
    check("dec.dreg", dec.dreg, e.dreg);
    check("dec.needed", {dec.in1_needed, dec.in2_needed}, {e.in1_needed, e.in2_needed});
    check("dec.ld_reg", dec.ld_reg, e.ld_reg);
    check("dec.mem_read", dec.mem_read, e.mem_read);
    check("dec.ld_mem", dec.ld_mem, e.ld_mem);
  endtask

  // One window through the stage, result one cycle later
  task automatic run_case();
    fetch_t f;
    build_window(f);
    drive(f);
    @(posedge clk);
    #1;
    check_dec(f);
  endtask

  task automatic expect_regs(input logic [2:0] in1, input logic [2:0] in2, input logic ld_reg,
                             input logic mem_read, input logic ld_mem);
    check("dec.in1", dec.in1, in1);
    check("dec.in2", dec.in2, in2);
    check("dec.ld_reg", dec.ld_reg, ld_reg);
    check("dec.mem_read", dec.mem_read, mem_read);
    check("dec.ld_mem", dec.ld_mem, ld_mem);
  endtask

  task automatic expect_flow(input logic hlt, input logic iret, input logic eip_change,
                             input logic [4:0] len);
    check("dec.ctrl.hlt", dec.ctrl.hlt, hlt);
    check("dec.ctrl.iret", dec.ctrl.iret, iret);
    check("dec.ctrl.eip_change", dec.ctrl.eip_change, eip_change);
    check("dec.fields.len", dec.fields.len, len);
  endtask

  task automatic test_reset();
    repeat (16) @(posedge clk);
    #1;
    check("dec_valid", dec_valid, 1'b0);
    check("dec", dec, '0);
    #1;
    reset = 1'b0;
  endtask

  task automatic test_prefixes();
    ins_q = '{8'h90};
    run_case();
    check("dec.prefix.count", dec.prefix.count, 3'd0);
    ins_q = '{8'hF2, 8'h90};
    run_case();
    check("dec.prefix.repne", dec.prefix.repne, 1'b1);
    ins_q = '{8'h66, 8'h05};
    run_case();
    check("dec.ctrl.imm_bytes", dec.ctrl.imm_bytes, 3'd2);
    ins_q = '{8'h26, 8'h3E, 8'h64, 8'h90};
    run_case();
    check("dec.prefix.seg", dec.prefix.seg, SEG_ES);
    ins_q = '{8'h65, 8'h36, 8'h90};
    run_case();
    check("dec.prefix.seg", dec.prefix.seg, SEG_SS);
    ins_q = '{8'h64, 8'h65, 8'h90};
    run_case();
    check("dec.prefix.seg", dec.prefix.seg, SEG_FS);
    // 2E after the opcode is not a prefix
    ins_q = '{8'h3E, 8'h90, 8'h2E};
    run_case();
    check("dec.prefix.count", dec.prefix.count, 3'd1);
    check("dec.prefix.seg", dec.prefix.seg, SEG_DS);
    ins_q = '{8'hF2, 8'h66, 8'h2E, 8'h0F, 8'h84};
    run_case();
    check("dec.prefix.count", dec.prefix.count, 3'd4);
    // Fifth prefix byte lies past the scan limit and is taken as the opcode
    ins_q = '{8'h26, 8'h26, 8'h26, 8'h26, 8'h26, 8'h90};
    run_case();
    check("dec.prefix.count", dec.prefix.count, 3'd4);
    check("dec.ctrl.legal", dec.ctrl.legal, 1'b0);
  endtask

  task automatic test_modrm_forms();
    logic [31:0] ops;
    logic [2:0]  rm;
    logic [2:0]  r;
    ops = 32'h8B89_0301;
    for (int o = 0; o < 4; o++) begin
      for (int s = 0; s < 2; s++) begin
        for (int m = 0; m < 4; m++) begin
          for (int k = 0; k < 3; k++) begin
            rm = (k == 0) ? 3'b000 : ((k == 1) ? 3'b100 : 3'b101);
            r  = rand_bits(3);
            ins_q.delete();
            if (s == 1) ins_q.push_back(PFX_SIZE);
            ins_q.push_back(ops[o*8 +: 8]);
            ins_q.push_back({m[1:0], r, rm});
            run_case();
          end
        end
      end
    end
  endtask

  task automatic test_immediates();
    logic [71:0] ops;
    logic [7:0]  op;
    ops = 72'hCF_F4_EB_E8_90_58_50_B8_05;
    for (int o = 0; o < 9; o++) begin
      for (int s = 0; s < 2; s++) begin
        op = ops[o*8 +: 8];
        if (op == 8'h50 || op == 8'h58 || op == 8'hB8) op[2:0] = rand_bits(3);
        ins_q.delete();
        if (s == 1) ins_q.push_back(PFX_SIZE);
        ins_q.push_back(op);
        run_case();
      end
    end
  endtask

  task automatic test_reg_mem();
    ins_q = '{8'h01, 8'h48};
    run_case();
    expect_regs(3'd0, 3'd1, 1'b0, 1'b1, 1'b1);
    ins_q = '{8'h03, 8'hC1};
    run_case();
    expect_regs(3'd0, 3'd1, 1'b1, 1'b0, 1'b0);
    ins_q = '{8'h8B, 8'h0E};
    run_case();
    expect_regs(3'd1, 3'd6, 1'b1, 1'b1, 1'b0);
    ins_q = '{8'h89, 8'h03};
    run_case();
    expect_regs(3'd3, 3'd0, 1'b0, 1'b0, 1'b1);
    ins_q = '{8'h53};
    run_case();
    expect_regs(3'd3, 3'd4, 1'b0, 1'b0, 1'b1);
    ins_q = '{8'h5E};
    run_case();
    expect_regs(3'd6, 3'd4, 1'b1, 1'b1, 1'b0);
    ins_q = '{8'h00};
    run_case();
    check("dec.ctrl", dec.ctrl, '0);
    ins_q = '{8'hFF};
    run_case();
    check("dec.ctrl", dec.ctrl, '0);
    ins_q = '{8'h0F, 8'h05};
    run_case();
    check("dec.ctrl", dec.ctrl, '0);
  endtask

  task automatic test_control_flow();
    ins_q = '{8'hF4};
    run_case();
    expect_flow(1'b1, 1'b0, 1'b0, 5'd1);
    ins_q = '{8'hCF};
    run_case();
    expect_flow(1'b0, 1'b1, 1'b0, 5'd1);
    ins_q = '{8'hEB};
    run_case();
    expect_flow(1'b0, 1'b0, 1'b1, 5'd2);
    ins_q = '{8'hE8};
    run_case();
    expect_flow(1'b0, 1'b0, 1'b1, 5'd5);
    ins_q = '{8'h66, 8'hE8};
    run_case();
    expect_flow(1'b0, 1'b0, 1'b1, 5'd4);
    ins_q = '{8'h0F, 8'h84};
    run_case();
    expect_flow(1'b0, 1'b0, 1'b1, 5'd6);
    ins_q = '{8'h66, 8'h0F, 8'h84};
    run_case();
    expect_flow(1'b0, 1'b0, 1'b1, 5'd5);
  endtask

  task automatic test_stall();
    decode_t held;
    logic    held_v;
    fetch_t  fb;
    fetch_t  fc;
    fetch_t  fd;
    ins_q = '{8'h01, 8'h48};
    run_case();
    held   = dec;
    held_v = dec_valid;
    ins_q = '{8'hE8};
    build_window(fb);
    // Invalid window under stall would clear dec_valid if it got through
    fb.valid = 1'b0;
    ins_q = '{8'h66, 8'hB8};
    build_window(fc);
    @(posedge clk);
    #2;
    stall = 1'b1;
    fetch = fb;
    repeat (2) begin
      @(posedge clk);
      #1;
      check("dec (stalled)", dec, held);
      check("dec_valid (stalled)", dec_valid, held_v);
    end
    // Window changes while still stalled
    #1;
    fetch = fc;
    @(posedge clk);
    #1;
    check("dec (stalled)", dec, held);
    #1;
    stall = 1'b0;
    @(posedge clk);
    #1;
    check_dec(fc);
    ins_q = '{8'h90};
    build_window(fd);
    fd.valid = 1'b0;
    drive(fd);
    @(posedge clk);
    #1;
    check_dec(fd);
  endtask

  initial begin
    reset = 1'b1;
    stall = 1'b0;
    fetch = '0;
    test_reset();
    test_prefixes();
    test_modrm_forms();
    test_immediates();
    test_reg_mem();
    test_control_flow();
    test_stall();
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: project.f
verilog/decode_pkg.sv
verilog/prefix_scan.sv
verilog/opcode_table.sv
verilog/instr_fields.sv
verilog/register_select.sv
verilog/decode_stage.sv
bench/tb_decode_stage.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - verilog/decode_pkg.sv
  - verilog/prefix_scan.sv
  - verilog/opcode_table.sv
  - verilog/instr_fields.sv
  - verilog/register_select.sv
  - verilog/decode_stage.sv
  - target: test
    files:
      - bench/tb_decode_stage.sv
